//--- sim/board_vectors.txt
# command then arguments; rows count from 0 at the top, tiles T=3 I=1 J=6 O=2 GARBAGE=8
# LOCK type r0 c0 r1 c1 r2 c2 r3 c3 / CHECKROW row hex, column 0 is the rightmost digit
CHECKROW 0 0000000000
CHECKROW 19 0000000000
CHECKLINES 0 0
CHECKTIME 0 0 0 0 0 0
LOCK 3 18 4 19 3 19 4 19 5
CHECKROW 19 0000333000
CHECKROW 18 0000030000
LOCK 1 19 6 19 7 19 8 19 9
LOCK 6 18 0 19 0 19 1 19 2
CHECKROW 19 0000030006
CHECKROW 18 0000000000
CHECKLINES 1 1
GARB 9
CHECKROW 19 0888888888
CHECKROW 18 0000030006
CHECKLINES 1 1
GARB 9
GARB 9
LOCK 1 16 9 17 9 18 9 19 9
CHECKROW 19 1000030006
CHECKROW 18 0000000000
CHECKLINES 4 3
GARB 2
CHECKROW 19 8888888088
CHECKROW 18 1000030006
CHECKLINES 4 3
RUN 37
CHECKTIME 7 0 0 0 0 0
RUN 520
CHECKTIME 1 1 1 0 0 0
LOCK 2 16 0 16 1 17 0 17 1
CHECKROW 17 0000000022
CHECKTIME 1 1 1 0 0 0
RUN 4443
CHECKTIME 0 0 0 1 0 0
START
CHECKROW 19 0000000000
CHECKLINES 0 0
CHECKTIME 0 0 0 0 0 0

//--- verilog.f
+incdir+hw
hw/tetris_pkg.sv
hw/locked_playfield.sv
hw/line_tracker.sv
hw/sprint_timer.sv
hw/tetris_board_top.sv
sim/tb_tetris_board.sv

//--- run_sim.sh
#!/bin/sh
# build and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_tetris_board --Mdir obj_dir -o tb_tetris_board
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_tetris_board > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- sim/tb_tetris_board.sv
`timescale 1ns/100ps
`include "tetris_defines.svh"

module tb_tetris_board;

    localparam int TICKS = 5;
    localparam int SETTLE_LIMIT = 100;

    logic                       clk;
    logic                       rst_n;
    logic                       game_start;
    logic                       lock;
    tetris_pkg::tile_t          lock_type;
    tetris_pkg::row_idx_t       lock_row0;
    tetris_pkg::row_idx_t       lock_row1;
    tetris_pkg::row_idx_t       lock_row2;
    tetris_pkg::row_idx_t       lock_row3;
    tetris_pkg::col_idx_t       lock_col0;
    tetris_pkg::col_idx_t       lock_col1;
    tetris_pkg::col_idx_t       lock_col2;
    tetris_pkg::col_idx_t       lock_col3;
    logic                       garbage;
    tetris_pkg::col_idx_t       hole_col;
    logic                       running;
    tetris_pkg::row_idx_t       rd_row;
    tetris_pkg::row_cells_t     rd_cells;
    logic                       settled;
    tetris_pkg::lines_cnt_t     lines_cleared;
    logic [2:0]                 last_clear;
    tetris_pkg::decimal_digit_t ms;
    tetris_pkg::decimal_digit_t cs;
    tetris_pkg::decimal_digit_t ds;
    tetris_pkg::sexagesimal_t   sec;
    tetris_pkg::sexagesimal_t   min;
    tetris_pkg::hours_t         hrs;

    // reference board and counters
    logic [3:0] model_board [0:`PLAYFIELD_ROWS-1][0:`PLAYFIELD_COLS-1];
    int         model_lines;
    int         model_last;
    int         tick_model;
    int         timer_model [0:5];
    int         field_limit [0:4];
    string      field_name [0:5];

    int errors;
    int timeouts;
    int lock_args [0:8];

    tetris_board_top #(.TICKS_PER_MS(TICKS)) dut (.*);

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic tetris_pkg::row_cells_t model_row(input int r);
        tetris_pkg::row_cells_t cells;
        for (int c = 0; c < `PLAYFIELD_COLS; c++) begin
            cells[c*`TILE_W +: `TILE_W] = model_board[r][c];
        end
        return cells;
    endfunction

    task automatic read_row(input int r, output tetris_pkg::row_cells_t cells);
        rd_row = tetris_pkg::row_idx_t'(r);
        next_cycle();
        cells = rd_cells;
    endtask

    task automatic compare_board();
        tetris_pkg::row_cells_t cells;
        for (int r = 0; r < `PLAYFIELD_ROWS; r++) begin
            read_row(r, cells);
            check_value($sformatf("board row %0d", r), 64'(model_row(r)), 64'(cells));
        end
    endtask

    task automatic wait_settled(input string what);
        int n;
        n = 0;
        while (!settled && n < SETTLE_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!settled) begin
            $display("timeout: board did not settle after %s within %0d cycles",
                     what, SETTLE_LIMIT);
            timeouts++;
        end
    endtask

    // full rows vanish, remaining rows stack on the floor in order
    task automatic clear_and_compact(output int cleared);
        logic [3:0] packed_rows [0:`PLAYFIELD_ROWS-1][0:`PLAYFIELD_COLS-1];
        logic       full;
        logic       empty;
        int         w;
        cleared = 0;
        for (int r = 0; r < `PLAYFIELD_ROWS; r++) begin
            full = 1'b1;
            for (int c = 0; c < `PLAYFIELD_COLS; c++) begin
                if (model_board[r][c] == 4'd0) full = 1'b0;
            end
            if (full) begin
                cleared++;
                for (int c = 0; c < `PLAYFIELD_COLS; c++) model_board[r][c] = 4'd0;
            end
        end
        packed_rows = '{default: '{default: 4'd0}};
        w = `PLAYFIELD_ROWS - 1;
        for (int r = `PLAYFIELD_ROWS - 1; r >= 0; r--) begin
            empty = 1'b1;
            for (int c = 0; c < `PLAYFIELD_COLS; c++) begin
                if (model_board[r][c] != 4'd0) empty = 1'b0;
            end
            if (!empty) begin
                for (int c = 0; c < `PLAYFIELD_COLS; c++) packed_rows[w][c] = model_board[r][c];
                w--;
            end
        end
        model_board = packed_rows;
        model_lines += cleared;
        if (cleared != 0) model_last = cleared;
    endtask

    task automatic lock_piece();
        int cleared;
        lock_type = tetris_pkg::tile_t'(lock_args[0]);
        lock_row0 = tetris_pkg::row_idx_t'(lock_args[1]);
        lock_col0 = tetris_pkg::col_idx_t'(lock_args[2]);
        lock_row1 = tetris_pkg::row_idx_t'(lock_args[3]);
        lock_col1 = tetris_pkg::col_idx_t'(lock_args[4]);
        lock_row2 = tetris_pkg::row_idx_t'(lock_args[5]);
        lock_col2 = tetris_pkg::col_idx_t'(lock_args[6]);
        lock_row3 = tetris_pkg::row_idx_t'(lock_args[7]);
        lock_col3 = tetris_pkg::col_idx_t'(lock_args[8]);
        lock = 1'b1;
        next_cycle();
        lock = 1'b0;
        for (int k = 0; k < 4; k++) begin
            model_board[lock_args[1+2*k]][lock_args[2+2*k]] = 4'(lock_args[0]);
        end
        clear_and_compact(cleared);
        if (cleared == 0) check_value("settled after lock", 64'(1), 64'(settled));
        wait_settled("lock");
        compare_board();
    endtask

    task automatic insert_garbage(input int hole);
        hole_col = tetris_pkg::col_idx_t'(hole);
        garbage = 1'b1;
        next_cycle();
        garbage = 1'b0;
        for (int r = 0; r < `PLAYFIELD_ROWS - 1; r++) begin
            for (int c = 0; c < `PLAYFIELD_COLS; c++) model_board[r][c] = model_board[r+1][c];
        end
        for (int c = 0; c < `PLAYFIELD_COLS; c++) begin
            model_board[`PLAYFIELD_ROWS-1][c] = (c == hole) ? 4'd0 : 4'd8;
        end
        wait_settled("garbage");
        compare_board();
    endtask

    task automatic start_game();
        game_start = 1'b1;
        next_cycle();
        game_start = 1'b0;
        model_board = '{default: '{default: 4'd0}};
        model_lines = 0;
        model_last = 0;
        tick_model = 0;
        timer_model = '{0, 0, 0, 0, 0, 0};
        wait_settled("game start");
        compare_board();
    endtask

    // one running cycle of the ms/cs/ds/sec/min/hrs chain
    task automatic advance_timer_model();
        logic carry;
        if (tick_model == TICKS - 1) begin
            tick_model = 0;
            carry = 1'b1;
            for (int i = 0; i < 6 && carry; i++) begin
                timer_model[i]++;
                if (i < 5 && timer_model[i] == field_limit[i]) begin
                    timer_model[i] = 0;
                end else begin
                    carry = 1'b0;
                end
            end
        end else begin
            tick_model++;
        end
    endtask

    task automatic run_timer(input int cycles);
        running = 1'b1;
        for (int i = 0; i < cycles; i++) begin
            next_cycle();
            advance_timer_model();
        end
        running = 1'b0;
    endtask

    task automatic check_lines(input int total, input int last);
        check_value("CHECKLINES total", 64'(total), 64'(lines_cleared));
        check_value("CHECKLINES last", 64'(last), 64'(last_clear));
        check_value("line model total", 64'(model_lines), 64'(lines_cleared));
        check_value("line model last", 64'(model_last), 64'(last_clear));
    endtask

    task automatic check_time(input int expected [0:5]);
        int dut_time [0:5];
        dut_time = '{int'(ms), int'(cs), int'(ds), int'(sec), int'(min), int'(hrs)};
        for (int i = 0; i < 6; i++) begin
            check_value({"CHECKTIME ", field_name[i]}, 64'(expected[i]), 64'(dut_time[i]));
            check_value({"timer model ", field_name[i]}, 64'(timer_model[i]),
                        64'(dut_time[i]));
        end
    endtask

    initial begin
        int                     fd;
        int                     code;
        int                     arg_a;
        int                     arg_b;
        int                     time_exp [0:5];
        logic [8*12-1:0]        cmd;
        logic [8*128-1:0]       rest;
        logic                   done;
        tetris_pkg::row_cells_t exp_row;
        tetris_pkg::row_cells_t cells;
        clk = 1'b0;
        rst_n = 1'b0;
        game_start = 1'b0;
        lock = 1'b0;
        lock_type = tetris_pkg::BLANK;
        {lock_row0, lock_row1, lock_row2, lock_row3} = '0;
        {lock_col0, lock_col1, lock_col2, lock_col3} = '0;
        garbage = 1'b0;
        hole_col = '0;
        running = 1'b0;
        rd_row = '0;
        errors = 0;
        timeouts = 0;
        model_board = '{default: '{default: 4'd0}};
        model_lines = 0;
        model_last = 0;
        tick_model = 0;
        timer_model = '{0, 0, 0, 0, 0, 0};
        field_limit = '{10, 10, 10, 60, 60};
        field_name = '{"ms", "cs", "ds", "sec", "min", "hrs"};
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("settled after reset", 64'(1), 64'(settled));
        compare_board();

        fd = $fopen("sim/board_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file sim/board_vectors.txt");
            errors++;
        end else begin
            done = 1'b0;
            while (!done && timeouts == 0) begin
                code = $fscanf(fd, "%s", cmd);
                if (code != 1) begin
                    done = 1'b1;
                end else begin
                    case (cmd)
                        96'("#"): code = $fgets(rest, fd);
                        96'("START"): start_game();
                        96'("LOCK"): begin
                            code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d",
                                           lock_args[0], lock_args[1], lock_args[2],
                                           lock_args[3], lock_args[4], lock_args[5],
                                           lock_args[6], lock_args[7], lock_args[8]);
                            lock_piece();
                        end
                        96'("GARB"): begin
                            code = $fscanf(fd, "%d", arg_a);
                            insert_garbage(arg_a);
                        end
                        96'("RUN"): begin
                            code = $fscanf(fd, "%d", arg_a);
                            run_timer(arg_a);
                        end
                        96'("CHECKROW"): begin
                            code = $fscanf(fd, "%d %h", arg_a, exp_row);
                            read_row(arg_a, cells);
                            check_value($sformatf("CHECKROW %0d", arg_a), 64'(exp_row),
                                        64'(cells));
                        end
                        96'("CHECKLINES"): begin
                            code = $fscanf(fd, "%d %d", arg_a, arg_b);
                            check_lines(arg_a, arg_b);
                        end
                        96'("CHECKTIME"): begin
                            code = $fscanf(fd, "%d %d %d %d %d %d", time_exp[0],
                                           time_exp[1], time_exp[2], time_exp[3],
                                           time_exp[4], time_exp[5]);
                            check_time(time_exp);
                        end
                        default: begin
                            $display("unknown command in the vector file");
                            errors++;
                            done = 1'b1;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- hw/tetris_board_top.sv
`timescale 1ns/100ps
`include "tetris_defines.svh"

module tetris_board_top #(
    parameter int TICKS_PER_MS = `TICKS_PER_MS_DEFAULT
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       game_start,
    input  logic                       lock,
    input  tetris_pkg::tile_t          lock_type,
    input  tetris_pkg::row_idx_t       lock_row0,
    input  tetris_pkg::row_idx_t       lock_row1,
    input  tetris_pkg::row_idx_t       lock_row2,
    input  tetris_pkg::row_idx_t       lock_row3,
    input  tetris_pkg::col_idx_t       lock_col0,
    input  tetris_pkg::col_idx_t       lock_col1,
    input  tetris_pkg::col_idx_t       lock_col2,
    input  tetris_pkg::col_idx_t       lock_col3,
    input  logic                       garbage,
    input  tetris_pkg::col_idx_t       hole_col,
    input  logic                       running,
    input  tetris_pkg::row_idx_t       rd_row,
    output tetris_pkg::row_cells_t     rd_cells,
    output logic                       settled,
    output tetris_pkg::lines_cnt_t     lines_cleared,
    output logic [2:0]                 last_clear,
    output tetris_pkg::decimal_digit_t ms,
    output tetris_pkg::decimal_digit_t cs,
    output tetris_pkg::decimal_digit_t ds,
    output tetris_pkg::sexagesimal_t   sec,
    output tetris_pkg::sexagesimal_t   min,
    output tetris_pkg::hours_t         hrs
);

    tetris_pkg::row_mask_t full_rows;

    locked_playfield u_playfield (
        .clk        (clk),
        .rst_n      (rst_n),
        .game_start (game_start),
        .lock       (lock),
        .lock_type  (lock_type),
        .lock_row0  (lock_row0),
        .lock_row1  (lock_row1),
        .lock_row2  (lock_row2),
        .lock_row3  (lock_row3),
        .lock_col0  (lock_col0),
        .lock_col1  (lock_col1),
        .lock_col2  (lock_col2),
        .lock_col3  (lock_col3),
        .garbage    (garbage),
        .hole_col   (hole_col),
        .rd_row     (rd_row),
        .rd_cells   (rd_cells),
        .full_rows  (full_rows),
        .empty_rows (),
        .settled    (settled)
    );

    // counts off the same full mask the playfield clears with
    line_tracker u_lines (
        .clk           (clk),
        .rst_n         (rst_n),
        .game_start    (game_start),
        .full_rows     (full_rows),
        .lines_cleared (lines_cleared),
        .last_clear    (last_clear)
    );

    sprint_timer #(
        .TICKS_PER_MS (TICKS_PER_MS)
    ) u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .game_start (game_start),
        .running    (running),
        .ms         (ms),
        .cs         (cs),
        .ds         (ds),
        .sec        (sec),
        .min        (min),
        .hrs        (hrs)
    );

endmodule

//--- hw/sprint_timer.sv
`timescale 1ns/100ps
`include "tetris_defines.svh"

module sprint_timer #(
    parameter int TICKS_PER_MS = `TICKS_PER_MS_DEFAULT
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       game_start,
    input  logic                       running,
    output tetris_pkg::decimal_digit_t ms,
    output tetris_pkg::decimal_digit_t cs,
    output tetris_pkg::decimal_digit_t ds,
    output tetris_pkg::sexagesimal_t   sec,
    output tetris_pkg::sexagesimal_t   min,
    output tetris_pkg::hours_t         hrs
);

    localparam int TICK_W = (TICKS_PER_MS > 1) ? $clog2(TICKS_PER_MS) : 1;

    logic [TICK_W-1:0] tick_cnt;

    logic tick_done;
    logic ms_wrap;
    logic cs_wrap;
    logic ds_wrap;
    logic sec_wrap;
    logic min_wrap;

    // carry chain, each stage wraps only when the one below does
    assign tick_done = (tick_cnt == TICK_W'(TICKS_PER_MS - 1));
    assign ms_wrap   = tick_done && (ms == 4'd9);
    assign cs_wrap   = ms_wrap && (cs == 4'd9);
    assign ds_wrap   = cs_wrap && (ds == 4'd9);
    assign sec_wrap  = ds_wrap && (sec == 6'd59);
    assign min_wrap  = sec_wrap && (min == 6'd59);

    always_ff @(posedge clk) begin
        if (!rst_n || game_start) begin
            tick_cnt <= '0;
            ms       <= '0;
            cs       <= '0;
            ds       <= '0;
            sec      <= '0;
            min      <= '0;
            hrs      <= '0;
        end else if (running) begin
            if (tick_done) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end

            if (tick_done) begin
                ms <= ms_wrap ? '0 : ms + 1'b1;
            end
            if (ms_wrap) begin
                cs <= cs_wrap ? '0 : cs + 1'b1;
            end
            if (cs_wrap) begin
                ds <= ds_wrap ? '0 : ds + 1'b1;
            end
            if (ds_wrap) begin
                sec <= sec_wrap ? '0 : sec + 1'b1;
            end
            if (sec_wrap) begin
                min <= min_wrap ? '0 : min + 1'b1;
            end
            // hours just keep counting
            if (min_wrap) begin
                hrs <= hrs + 1'b1;
            end
        end
    end

    a_decimal_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ms < 4'd10) && (cs < 4'd10) && (ds < 4'd10)
    );

    a_sexagesimal_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (sec < 6'd60) && (min < 6'd60)
    );

endmodule

//--- hw/line_tracker.sv
`timescale 1ns/100ps
`include "tetris_defines.svh"

module line_tracker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   game_start,
    input  tetris_pkg::row_mask_t  full_rows,
    output tetris_pkg::lines_cnt_t lines_cleared,
    output logic [2:0]             last_clear
);

    tetris_pkg::row_idx_t  clear_count;
    logic [`LINES_W:0]     lines_sum;

    // rows being cleared this cycle
    always_comb begin
        clear_count = '0;
        for (int r = 0; r < `PLAYFIELD_ROWS; r++) begin
            clear_count = clear_count + tetris_pkg::row_idx_t'(full_rows[r]);
        end
    end

    assign lines_sum = {1'b0, lines_cleared} + (`LINES_W+1)'(clear_count);

    always_ff @(posedge clk) begin
        if (!rst_n || game_start) begin
            lines_cleared <= '0;
            last_clear    <= '0;
        end else begin
            // saturate at all ones
            if (lines_sum[`LINES_W]) begin
                lines_cleared <= '1;
            end else begin
                lines_cleared <= lines_sum[`LINES_W-1:0];
            end
            if (clear_count != '0) begin
                last_clear <= clear_count[2:0];
            end
        end
    end

    // one lock touches at most four rows, and full rows live a single cycle
    a_clear_max_four: assert property (
        @(posedge clk) disable iff (!rst_n)
        clear_count <= tetris_pkg::row_idx_t'(4)
    );

endmodule

//--- hw/locked_playfield.sv
`timescale 1ns/100ps
`include "tetris_defines.svh"

module locked_playfield (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  game_start,
    input  logic                  lock,
    input  tetris_pkg::tile_t     lock_type,
    input  tetris_pkg::row_idx_t  lock_row0,
    input  tetris_pkg::row_idx_t  lock_row1,
    input  tetris_pkg::row_idx_t  lock_row2,
    input  tetris_pkg::row_idx_t  lock_row3,
    input  tetris_pkg::col_idx_t  lock_col0,
    input  tetris_pkg::col_idx_t  lock_col1,
    input  tetris_pkg::col_idx_t  lock_col2,
    input  tetris_pkg::col_idx_t  lock_col3,
    input  logic                  garbage,
    input  tetris_pkg::col_idx_t  hole_col,
    input  tetris_pkg::row_idx_t  rd_row,
    output tetris_pkg::row_cells_t rd_cells,
    output tetris_pkg::row_mask_t full_rows,
    output tetris_pkg::row_mask_t empty_rows,
    output logic                  settled
);

    tetris_pkg::tile_t     board       [`PLAYFIELD_ROWS][`PLAYFIELD_COLS];
    tetris_pkg::tile_t     garbage_row [`PLAYFIELD_COLS];

    // bit r set when row r pulls down the row above it
    tetris_pkg::row_mask_t drop_rows;

    // row scan
    always_comb begin
        for (int r = 0; r < `PLAYFIELD_ROWS; r++) begin
            full_rows[r]  = 1'b1;
            empty_rows[r] = 1'b1;
            for (int c = 0; c < `PLAYFIELD_COLS; c++) begin
                if (board[r][c] == tetris_pkg::BLANK) begin
                    full_rows[r] = 1'b0;
                end else begin
                    empty_rows[r] = 1'b0;
                end
            end
        end
    end

    // a full row is cleared in place, never dropped
    always_comb begin
        drop_rows = '0;
        for (int r = 1; r < `PLAYFIELD_ROWS; r++) begin
            drop_rows[r] = empty_rows[r] && !empty_rows[r-1] && !full_rows[r-1];
        end
    end

    // nothing to clear and no gap under a filled row
    assign settled = !(|full_rows) && !(|drop_rows);

    always_comb begin
        for (int c = 0; c < `PLAYFIELD_COLS; c++) begin
            garbage_row[c] = (tetris_pkg::col_idx_t'(c) == hole_col) ?
                             tetris_pkg::BLANK : tetris_pkg::GARBAGE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || game_start) begin
            for (int r = 0; r < `PLAYFIELD_ROWS; r++) begin
                board[r] <= '{default: tetris_pkg::BLANK};
            end
        end else if (garbage) begin
            // whole stack rises, top row falls off
            for (int r = 0; r < `PLAYFIELD_ROWS - 1; r++) begin
                board[r] <= board[r+1];
            end
            board[`PLAYFIELD_ROWS-1] <= garbage_row;
        end else begin
            for (int r = 0; r < `PLAYFIELD_ROWS; r++) begin
                if (full_rows[r]) begin
                    board[r] <= '{default: tetris_pkg::BLANK};
                end
            end
            // gap rises one row per cycle
            for (int r = 1; r < `PLAYFIELD_ROWS; r++) begin
                if (drop_rows[r]) begin
                    board[r]   <= board[r-1];
                    board[r-1] <= '{default: tetris_pkg::BLANK};
                end
            end
            if (lock) begin
                board[lock_row0][lock_col0] <= lock_type;
                board[lock_row1][lock_col1] <= lock_type;
                board[lock_row2][lock_col2] <= lock_type;
                board[lock_row3][lock_col3] <= lock_type;
            end
        end
    end

    // read port, out of range rows read blank
    always_comb begin
        rd_cells = '0;
        if (rd_row < tetris_pkg::row_idx_t'(`PLAYFIELD_ROWS)) begin
            for (int c = 0; c < `PLAYFIELD_COLS; c++) begin
                rd_cells[c*`TILE_W +: `TILE_W] = board[rd_row][c];
            end
        end
    end

    // caller contract
    a_lock_garbage_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(lock && garbage)
    );

    a_hole_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        garbage |-> (hole_col < tetris_pkg::col_idx_t'(`PLAYFIELD_COLS))
    );

    // a lock during a collapse would land on moving rows
    a_lock_when_settled: assert property (
        @(posedge clk) disable iff (!rst_n) lock |-> settled
    );

endmodule

//--- hw/tetris_pkg.sv
`include "tetris_defines.svh"

package tetris_pkg;

    // locked cell contents
    typedef enum logic [`TILE_W-1:0] {
        BLANK   = 4'd0,
        I       = 4'd1,
        O       = 4'd2,
        T       = 4'd3,
        S       = 4'd4,
        Z       = 4'd5,
        J       = 4'd6,
        L       = 4'd7,
        GARBAGE = 4'd8
    } tile_t;

    // row 0 is the top row
    typedef logic [`ROW_W-1:0] row_idx_t;
    typedef logic [`COL_W-1:0] col_idx_t;

    // one row of tile codes, column 0 in the low nibble
    typedef logic [`PLAYFIELD_COLS*`TILE_W-1:0] row_cells_t;
    typedef logic [`PLAYFIELD_ROWS-1:0] row_mask_t;

    typedef logic [`LINES_W-1:0] lines_cnt_t;

    // sprint timer fields
    typedef logic [3:0] decimal_digit_t;
    typedef logic [5:0] sexagesimal_t;
    typedef logic [4:0] hours_t;

endpackage

//--- hw/tetris_defines.svh
`ifndef TETRIS_DEFINES_SVH
`define TETRIS_DEFINES_SVH

// playfield geometry
`define PLAYFIELD_ROWS 20
`define PLAYFIELD_COLS 10

// index and code widths
`define ROW_W 5
`define COL_W 4
`define TILE_W 4

// lines counter width
`define LINES_W 10

// clock cycles per millisecond at 50 MHz
`define TICKS_PER_MS_DEFAULT 50000

`endif
